/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rv_pipe_tb
FILELIST  = rv_pipe.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_config.svh"

module decode_unit (
        input  wire logic                 clk,
        input  wire logic                 i_reset,
        input  wire rv_pipe_pkg::if_id_t  i_if_id,
        input  wire rv_pipe_pkg::id_ex_t  i_ex,
        input  wire rv_pipe_pkg::ex_mem_t i_mem,
        input  wire rv_pipe_pkg::mem_wb_t i_wb,
        output rv_pipe_pkg::id_ex_t       o_id_ex,
        output logic                      o_stall,
        output logic                      o_redirect,
        output logic [`RV_IMEM_AW-1:0]    o_target,
        output logic                      o_done
);

import rv_pipe_pkg::*;

logic [`RV_XLEN-1:0]   instr;
opcode_t               opcode;
logic [`RV_REG_AW-1:0] rs1;
logic [`RV_REG_AW-1:0] rs2;
logic [`RV_REG_AW-1:0] rd;
logic [2:0]            funct3;
logic [`RV_XLEN-1:0]   imm_i;
logic [`RV_XLEN-1:0]   imm_s;
logic [`RV_XLEN-1:0]   imm_b;
ctrl_t                 ctrl;
logic [`RV_XLEN-1:0]   imm;
logic                  uses_rs1;
logic                  uses_rs2;
logic                  is_branch;
logic [`RV_XLEN-1:0]   regs [2**`RV_REG_AW];
logic [`RV_XLEN-1:0]   rs1_data;
logic [`RV_XLEN-1:0]   rs2_data;
logic                  load_use;
logic                  branch_wait;
logic                  taken;

//////////////////////////////////////////////////////////////////////
// Field extraction

assign instr  = i_if_id.instr;
assign opcode = opcode_t'(instr[6:0]);
assign rd     = instr[11:7];
assign funct3 = instr[14:12];
assign rs1    = instr[19:15];
assign rs2    = instr[24:20];

assign imm_i = {{20{instr[31]}}, instr[31:20]};
assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
// Byte offset, bit 0 always zero
assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

//////////////////////////////////////////////////////////////////////
// Control

always_comb begin
        ctrl      = '0;
        imm       = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        is_branch = 1'b0;
        if (i_if_id.valid) begin
                case (opcode)
                OPC_OP: begin
                        ctrl.reg_write = 1'b1;
                        uses_rs1       = 1'b1;
                        uses_rs2       = 1'b1;
                        case (funct3)
                        3'b000:  ctrl.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                        3'b010:  ctrl.alu_op = ALU_SLT;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        3'b111:  ctrl.alu_op = ALU_AND;
                        default: ctrl.alu_op = ALU_ADD;
                        endcase
                end
                // ADDI only
                OPC_OP_IMM: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src   = 1'b1;
                        imm            = imm_i;
                        uses_rs1       = 1'b1;
                end
                OPC_LOAD: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.mem_read  = 1'b1;
                        ctrl.alu_src   = 1'b1;
                        imm            = imm_i;
                        uses_rs1       = 1'b1;
                end
                OPC_STORE: begin
                        ctrl.mem_write = 1'b1;
                        ctrl.alu_src   = 1'b1;
                        imm            = imm_s;
                        uses_rs1       = 1'b1;
                        uses_rs2       = 1'b1;
                end
                // BEQ and BNE
                OPC_BRANCH: begin
                        imm       = imm_b;
                        uses_rs1  = 1'b1;
                        uses_rs2  = 1'b1;
                        is_branch = (funct3[2:1] == 2'b00);
                end
                default: begin
                end
                endcase
        end
        // x0 never written
        if (rd == '0)
                ctrl.reg_write = 1'b0;
end

//////////////////////////////////////////////////////////////////////
// Register file, write-first read

always_ff @(posedge clk) begin
        if (i_wb.reg_write && (i_wb.rd != '0)) begin
                regs[i_wb.rd] <= i_wb.result;
        end
end

assign rs1_data = (rs1 == '0) ? '0 :
        (i_wb.reg_write && (i_wb.rd == rs1)) ? i_wb.result : regs[rs1];
assign rs2_data = (rs2 == '0) ? '0 :
        (i_wb.reg_write && (i_wb.rd == rs2)) ? i_wb.result : regs[rs2];

//////////////////////////////////////////////////////////////////////
// Hazards and branch resolution

// Load in EX feeding this instruction
assign load_use = i_ex.ctrl.mem_read && (i_ex.rd != '0) &&
        ((uses_rs1 && (i_ex.rd == rs1)) || (uses_rs2 && (i_ex.rd == rs2)));

// Branch operands must already be in the register file
assign branch_wait = is_branch &&
        ((i_ex.ctrl.reg_write && ((i_ex.rd == rs1) || (i_ex.rd == rs2))) ||
         (i_mem.ctrl.reg_write && ((i_mem.rd == rs1) || (i_mem.rd == rs2))));

assign o_stall = load_use || branch_wait;

// funct3 bit 0 selects BNE
assign taken = is_branch &&
        (funct3[0] ? (rs1_data != rs2_data) : (rs1_data == rs2_data));

assign o_redirect = taken && !o_stall;
// Word-addressed PC
assign o_target   = i_if_id.pc + imm[`RV_IMEM_AW+1:2];

always_comb begin
        o_id_ex.ctrl     = ctrl;
        o_id_ex.rs1      = rs1;
        o_id_ex.rs2      = rs2;
        o_id_ex.rd       = rd;
        o_id_ex.rs1_data = rs1_data;
        o_id_ex.rs2_data = rs2_data;
        o_id_ex.imm      = imm;
        // End-of-program marker
        o_id_ex.halt     = i_if_id.valid && (instr == '0);
end

// Sticky once the marker reaches writeback
always_ff @(posedge clk) begin
        if (i_reset)
                o_done <= 1'b0;
        else if (i_wb.halt)
                o_done <= 1'b1;
end

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_config.svh"

module execute_unit (
        input  wire rv_pipe_pkg::id_ex_t  i_id_ex,
        input  wire rv_pipe_pkg::mem_wb_t i_mem_fwd,
        input  wire rv_pipe_pkg::mem_wb_t i_wb_fwd,
        output rv_pipe_pkg::ex_mem_t      o_ex_mem
);

import rv_pipe_pkg::*;

// MEM wins over WB, x0 never forwards
function automatic fwd_sel_t pick_fwd(input logic [`RV_REG_AW-1:0] src,
                                      input mem_wb_t mem_fwd,
                                      input mem_wb_t wb_fwd);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (src != '0) begin
                if (mem_fwd.reg_write && (mem_fwd.rd == src))
                        sel = FWD_MEM;
                else if (wb_fwd.reg_write && (wb_fwd.rd == src))
                        sel = FWD_WB;
        end
        return sel;
endfunction

function automatic logic [`RV_XLEN-1:0] fwd_value(input fwd_sel_t sel,
                                                  input logic [`RV_XLEN-1:0] reg_val,
                                                  input mem_wb_t mem_fwd,
                                                  input mem_wb_t wb_fwd);
        case (sel)
        FWD_MEM: return mem_fwd.result;
        FWD_WB:  return wb_fwd.result;
        default: return reg_val;
        endcase
endfunction

fwd_sel_t            sel_a;
fwd_sel_t            sel_b;
logic [`RV_XLEN-1:0] op_a;
// Forwarded rs2, also the store data
logic [`RV_XLEN-1:0] rs2_val;
logic [`RV_XLEN-1:0] op_b;
logic [`RV_XLEN-1:0] result;
logic                lt;

assign sel_a   = pick_fwd(i_id_ex.rs1, i_mem_fwd, i_wb_fwd);
assign sel_b   = pick_fwd(i_id_ex.rs2, i_mem_fwd, i_wb_fwd);
assign op_a    = fwd_value(sel_a, i_id_ex.rs1_data, i_mem_fwd, i_wb_fwd);
assign rs2_val = fwd_value(sel_b, i_id_ex.rs2_data, i_mem_fwd, i_wb_fwd);
assign op_b    = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rs2_val;

// Signed compare for SLT
assign lt = $signed(op_a) < $signed(op_b);

always_comb begin
        case (i_id_ex.ctrl.alu_op)
        ALU_ADD: result = op_a + op_b;
        ALU_SUB: result = op_a - op_b;
        ALU_AND: result = op_a & op_b;
        ALU_OR:  result = op_a | op_b;
        ALU_XOR: result = op_a ^ op_b;
        ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, lt};
        default: result = '0;
        endcase
end

always_comb begin
        o_ex_mem.ctrl       = i_id_ex.ctrl;
        o_ex_mem.rd         = i_id_ex.rd;
        o_ex_mem.alu_result = result;
        o_ex_mem.store_data = rs2_val;
        o_ex_mem.halt       = i_id_ex.halt;
end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_config.svh"

module fetch_unit (
        input  wire logic                   clk,
        input  wire logic                   i_reset,
        input  wire rv_pipe_pkg::imem_wr_t  i_imem_wr,
        input  wire logic                   i_start,
        input  wire logic                   i_stall,
        input  wire logic                   i_redirect,
        input  wire logic [`RV_IMEM_AW-1:0] i_target,
        output rv_pipe_pkg::if_id_t         o_if_id
);

logic [`RV_XLEN-1:0]    imem [2**`RV_IMEM_AW];
logic [`RV_IMEM_AW-1:0] pc;
logic [`RV_XLEN-1:0]    word;
// Fetch active between start and the end marker
logic                   running;
// Core has left the idle state
logic                   started;
logic                   marker;

// Program load, accepted only while idle
always_ff @(posedge clk) begin
        if (i_imem_wr.valid && !started) begin
                imem[i_imem_wr.addr] <= i_imem_wr.data;
        end
end

assign word = imem[pc];

// All-zero word ends the program unless squashed
assign marker = running && (word == '0) && !i_redirect;

always_ff @(posedge clk) begin
        if (i_reset) begin
                pc      <= '0;
                running <= 1'b0;
                started <= 1'b0;
        end else if (i_start && !started) begin
                pc      <= '0;
                running <= 1'b1;
                started <= 1'b1;
        end else if (running) begin
                if (i_redirect) begin
                        pc <= i_target;
                end else if (!i_stall) begin
                        // PC freezes on the marker
                        if (marker)
                                running <= 1'b0;
                        else
                                pc <= pc + 1'b1;
                end
        end
end

// Marker still travels as a valid word, decode flags it as halt
always_comb begin
        o_if_id.valid = running;
        o_if_id.pc    = pc;
        o_if_id.instr = word;
end

endmodule

`default_nettype wire

/* logic/mem_access_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_config.svh"

module mem_access_unit (
        input  wire logic                 clk,
        input  wire rv_pipe_pkg::ex_mem_t i_ex_mem,
        output rv_pipe_pkg::mem_wb_t      o_mem_wb
);

logic [`RV_XLEN-1:0]    dmem [2**`RV_DMEM_AW];
// Word index from the byte address
logic [`RV_DMEM_AW-1:0] addr;
logic [`RV_XLEN-1:0]    load_data;

assign addr = i_ex_mem.alu_result[`RV_DMEM_AW+1:2];

// SW only, whole word
always_ff @(posedge clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
                dmem[addr] <= i_ex_mem.store_data;
        end
end

assign load_data = dmem[addr];

// Also the MEM forwarding source, so loads forward their data
always_comb begin
        o_mem_wb.reg_write = i_ex_mem.ctrl.reg_write;
        o_mem_wb.rd        = i_ex_mem.rd;
        o_mem_wb.result    = i_ex_mem.ctrl.mem_read ? load_data : i_ex_mem.alu_result;
        o_mem_wb.halt      = i_ex_mem.halt;
end

endmodule

`default_nettype wire

/* logic/rv_pipe_config.svh */
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// Data word width
`define RV_XLEN 32

// Instruction memory depth as a word address width
`define RV_IMEM_AW 8

// Data memory depth as a word address width
`define RV_DMEM_AW 6

// Register index width, 32 registers
`define RV_REG_AW 5

`endif

/* logic/rv_pipe_pkg.sv */
`default_nettype none

`include "rv_pipe_config.svh"

package rv_pipe_pkg;

// Major opcodes of the supported subset
typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011
} opcode_t;

// ALU functions, ADD at zero so a bubble is an add
typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
} alu_op_t;

// Operand source in execute
typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
} fwd_sel_t;

typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        // Second operand from immediate
        logic    alu_src;
        alu_op_t alu_op;
} ctrl_t;

typedef struct packed {
        logic                   valid;
        logic [`RV_IMEM_AW-1:0] pc;
        logic [`RV_XLEN-1:0]    instr;
} if_id_t;

typedef struct packed {
        ctrl_t                 ctrl;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   imm;
        logic                  halt;
} id_ex_t;

typedef struct packed {
        ctrl_t                 ctrl;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   alu_result;
        logic [`RV_XLEN-1:0]   store_data;
        logic                  halt;
} ex_mem_t;

typedef struct packed {
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;
        logic                  halt;
} mem_wb_t;

// Program load port, one word per strobe
typedef struct packed {
        logic                   valid;
        logic [`RV_IMEM_AW-1:0] addr;
        logic [`RV_XLEN-1:0]    data;
} imem_wr_t;

// Committed register write
typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
} wb_obs_t;

endpackage

`default_nettype wire

/* logic/rv_pipe_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_config.svh"

module rv_pipe_top (
        input  wire logic                  clk,
        input  wire logic                  i_reset,
        input  wire rv_pipe_pkg::imem_wr_t i_imem_wr,
        input  wire logic                  i_start,
        output rv_pipe_pkg::wb_obs_t       o_wb,
        output logic                       o_done
);

import rv_pipe_pkg::*;

if_id_t                 if_id_d;
if_id_t                 if_id_q;
id_ex_t                 id_ex_d;
id_ex_t                 id_ex_q;
ex_mem_t                ex_mem_d;
ex_mem_t                ex_mem_q;
// Unregistered copy is the MEM forwarding source
mem_wb_t                mem_wb_d;
mem_wb_t                mem_wb_q;
logic                   stall;
logic                   redirect;
logic [`RV_IMEM_AW-1:0] target;

//////////////////////////////////////////////////////////////////////
// Fetch and decode

fetch_unit u_fetch (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_imem_wr  (i_imem_wr),
        .i_start    (i_start),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .o_if_id    (if_id_d)
);

// Held on stall, squashed on taken branch
stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .i_reset(i_reset), .i_hold(stall), .i_bubble(redirect),
        .i_d(if_id_d), .o_q(if_id_q)
);

decode_unit u_decode (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_if_id    (if_id_q),
        .i_ex       (id_ex_q),
        .i_mem      (ex_mem_q),
        .i_wb       (mem_wb_q),
        .o_id_ex    (id_ex_d),
        .o_stall    (stall),
        .o_redirect (redirect),
        .o_target   (target),
        .o_done     (o_done)
);

// Stall inserts a bubble into EX
stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(stall),
        .i_d(id_ex_d), .o_q(id_ex_q)
);

//////////////////////////////////////////////////////////////////////
// Execute, memory and writeback

execute_unit u_execute (
        .i_id_ex   (id_ex_q),
        .i_mem_fwd (mem_wb_d),
        .i_wb_fwd  (mem_wb_q),
        .o_ex_mem  (ex_mem_d)
);

stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(1'b0),
        .i_d(ex_mem_d), .o_q(ex_mem_q)
);

mem_access_unit u_mem (
        .clk      (clk),
        .i_ex_mem (ex_mem_q),
        .o_mem_wb (mem_wb_d)
);

stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .i_reset(i_reset), .i_hold(1'b0), .i_bubble(1'b0),
        .i_d(mem_wb_d), .o_q(mem_wb_q)
);

// Writeback observation, reg_write is already clear for x0
assign o_wb.valid = mem_wb_q.reg_write;
assign o_wb.rd    = mem_wb_q.rd;
assign o_wb.data  = mem_wb_q.result;

endmodule

`default_nettype wire

/* logic/stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

// Generic pipeline latch between two stages
module stage_reg #(
        parameter type payload_t = logic
) (
        input  wire logic     clk,
        input  wire logic     i_reset,
        input  wire logic     i_hold,
        input  wire logic     i_bubble,
        input  wire payload_t i_d,
        output payload_t      o_q
);

always_ff @(posedge clk) begin
        // All-zero payload is a bubble, no write and no halt
        if (i_reset || i_bubble) begin
                o_q <= '0;
        end
        // Keep the current instruction during a stall
        else if (!i_hold) begin
                o_q <= i_d;
        end
end

endmodule

`default_nettype wire

/* rv_pipe.f */
+incdir+logic
logic/rv_pipe_pkg.sv
logic/stage_reg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/mem_access_unit.sv
logic/rv_pipe_top.sv
testbench/clock_gen.sv
testbench/rv_pipe_chk.sv
testbench/rv_pipe_tb.sv

/* testbench/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

// Free-running clock and power-on reset
module clock_gen #(
        parameter int PERIOD       = 100,
        parameter int RESET_CYCLES = 4
) (
        output logic o_clk,
        output logic o_reset
);

initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
end

// Reset released on a rising edge
initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
end

endmodule

`default_nettype wire

/* testbench/rv_pipe_chk.sv */
`timescale 1ns/100ps
`default_nettype none

// Protocol rules on the top-level ports
module rv_pipe_chk (
        input wire logic                  clk,
        input wire logic                  i_reset,
        input wire rv_pipe_pkg::imem_wr_t i_imem_wr,
        input wire logic                  i_start,
        input wire rv_pipe_pkg::wb_obs_t  i_wb,
        input wire logic                  i_done
);

// x0 writes are dropped in decode
wb_no_x0: assert property (@(posedge clk) disable iff (i_reset)
        i_wb.valid |-> (i_wb.rd != '0))
        else $error("register write to x0 seen on o_wb");

// Done is sticky until reset
done_sticky: assert property (@(posedge clk) disable iff (i_reset)
        !$fell(i_done))
        else $error("o_done fell outside reset");

// Nothing commits after the halt marker
no_wb_after_done: assert property (@(posedge clk) disable iff (i_reset)
        i_done |-> !i_wb.valid)
        else $error("o_wb.valid while o_done is high");

load_not_with_start: assert property (@(posedge clk) disable iff (i_reset)
        !(i_imem_wr.valid && i_start))
        else $error("program load and start in the same cycle");

endmodule

bind rv_pipe_top rv_pipe_chk chk_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_imem_wr (i_imem_wr),
        .i_start   (i_start),
        .i_wb      (o_wb),
        .i_done    (o_done)
);

`default_nettype wire

/* testbench/rv_pipe_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_pipe_config.svh"

module rv_pipe_tb;

import rv_pipe_pkg::*;

localparam int PROG_LEN    = 28;
// Four cycles per instruction, the load, and slack for stalls
localparam int CYCLE_LIMIT = PROG_LEN * 4 + PROG_LEN + 50;

logic                clk;
logic                i_reset;
imem_wr_t            i_imem_wr;
logic                i_start;
wb_obs_t             o_wb;
logic                o_done;
logic [`RV_XLEN-1:0] prog [PROG_LEN];
// Ordered register writes from the ISA model
wb_obs_t             expected [$];
integer              seed;
int                  value_errors = 0;
int                  other_errors = 0;
int                  cycles = 0;

clock_gen #(.PERIOD(100), .RESET_CYCLES(4)) clock_gen_i (
        .o_clk   (clk),
        .o_reset (i_reset)
);

rv_pipe_top rv_pipe_top_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_imem_wr (i_imem_wr),
        .i_start   (i_start),
        .o_wb      (o_wb),
        .o_done    (o_done)
);

//////////////////////////////////////////////////////////////////////
// Instruction encoders

// Register-register ALU op, sub selects SUB
function automatic logic [31:0] rr_instr(input logic sub, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// Byte offset, bne picks BNE over BEQ
function automatic logic [31:0] branch_instr(input logic bne, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], 7'b1100011};
endfunction

//////////////////////////////////////////////////////////////////////
// Program and ISA model

function automatic void build_program();
        logic [31:0] rnd [3];
        for (int i = 0; i < 3; i++)
                rnd[i] = $random(seed);
        prog[0]  = addi_instr(1, 0, rnd[0][11:0]);
        prog[1]  = addi_instr(2, 0, rnd[1][11:0]);
        prog[2]  = addi_instr(3, 0, rnd[2][11:0]);
        // Dependent chain through MEM and WB forwarding
        prog[3]  = rr_instr(1'b0, 3'b000, 4, 1, 2);
        prog[4]  = rr_instr(1'b1, 3'b000, 5, 4, 3);
        prog[5]  = rr_instr(1'b0, 3'b111, 6, 5, 4);
        prog[6]  = rr_instr(1'b0, 3'b110, 7, 6, 1);
        prog[7]  = rr_instr(1'b0, 3'b100, 8, 7, 2);
        prog[8]  = rr_instr(1'b0, 3'b010, 9, 1, 2);
        prog[9]  = rr_instr(1'b0, 3'b010, 10, 2, 1);
        prog[10] = sw_instr(4, 0, 12'd0);
        prog[11] = sw_instr(5, 0, 12'd4);
        // Load then immediate use
        prog[12] = lw_instr(11, 0, 12'd0);
        prog[13] = rr_instr(1'b0, 3'b000, 12, 11, 3);
        prog[14] = lw_instr(13, 0, 12'd4);
        prog[15] = lw_instr(14, 0, 12'd0);
        prog[16] = rr_instr(1'b1, 3'b000, 15, 13, 14);
        // Taken BEQ right behind its source, skips one
        prog[17] = branch_instr(1'b0, 15, 15, 13'd8);
        prog[18] = addi_instr(16, 0, 12'd99);
        prog[19] = branch_instr(1'b1, 1, 1, 13'd8);
        prog[20] = addi_instr(17, 0, 12'd5);
        prog[21] = branch_instr(1'b0, 1, 2, 13'd8);
        prog[22] = addi_instr(18, 17, 12'd7);
        prog[23] = addi_instr(19, 17, 12'd1);
        // Taken only if the fresh x19 reaches decode
        prog[24] = branch_instr(1'b1, 19, 0, 13'd8);
        prog[25] = addi_instr(20, 0, 12'd1);
        prog[26] = rr_instr(1'b0, 3'b010, 21, 3, 0);
        // End marker
        prog[27] = '0;
endfunction

// Reference interpreter, fills the expected write list
function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] dmem [2**`RV_DMEM_AW];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] imm_b;
        logic        writes;
        int          pc;
        int          steps;
        for (int r = 0; r < 32; r++)
                regs[r] = '0;
        pc    = 0;
        steps = 0;
        while (pc >= 0 && pc < PROG_LEN && prog[pc] != '0 && steps < 4 * PROG_LEN) begin
                w      = prog[pc];
                a      = regs[w[19:15]];
                b      = regs[w[24:20]];
                res    = '0;
                writes = 1'b0;
                steps++;
                pc++;
                case (w[6:0])
                7'b0110011: begin
                        writes = 1'b1;
                        case (w[14:12])
                        3'b000:  res = w[30] ? a - b : a + b;
                        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                        endcase
                end
                7'b0010011: begin
                        writes = 1'b1;
                        res    = a + {{20{w[31]}}, w[31:20]};
                end
                7'b0000011: begin
                        writes = 1'b1;
                        addr   = a + {{20{w[31]}}, w[31:20]};
                        res    = dmem[addr[`RV_DMEM_AW+1:2]];
                end
                7'b0100011: begin
                        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                        dmem[addr[`RV_DMEM_AW+1:2]] = b;
                end
                default: begin
                        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                        // pc already points past the branch
                        if (w[12] ? (a != b) : (a == b))
                                pc = pc - 1 + int'($signed(imm_b)) / 4;
                end
                endcase
                if (writes && w[11:7] != 5'd0) begin
                        regs[w[11:7]] = res;
                        expected.push_back({1'b1, w[11:7], res});
                end
        end
endfunction

task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
                $display("TESTBENCH PASSED");
        end else begin
                $display("TESTBENCH FAILED");
        end
        $finish;
endtask

//////////////////////////////////////////////////////////////////////
// Stimulus, comparison, timeout

initial begin
        i_imem_wr = '0;
        i_start   = 1'b0;
        seed      = 47;
        build_program();
        run_reference();
        wait (i_reset === 1'b0);
        for (int a = 0; a < PROG_LEN; a++) begin
                @(posedge clk);
                i_imem_wr <= {1'b1, 8'(a), prog[a]};
        end
        @(posedge clk);
        i_imem_wr <= '0;
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        while (!o_done)
                @(posedge clk);
        // Every write is out before done rises
        assert (expected.size() == 0) else begin
                other_errors++;
                $display("o_done rose with %0d expected register writes still missing",
                         expected.size());
        end
        // A few idle cycles to catch late writes
        repeat (4) @(posedge clk);
        finish_run();
end

always @(posedge clk) begin
        wb_obs_t want;
        if (!i_reset && o_wb.valid) begin
                assert (!o_done) else begin
                        other_errors++;
                        $display("Register write to x%0d after o_done at %0t", o_wb.rd, $time);
                end
                if (expected.size() == 0) begin
                        other_errors++;
                        $display("Unexpected register write to x%0d at %0t", o_wb.rd, $time);
                end else begin
                        want = expected.pop_front();
                        assert (o_wb.rd == want.rd) else begin
                                value_errors++;
                                $display("** Error at %0t: o_wb.rd expected %0d, got %0d",
                                         $time, want.rd, o_wb.rd);
                        end
                        assert (o_wb.data == want.data) else begin
                                value_errors++;
                                $display("** Error at %0t: o_wb.data expected %h, got %h",
                                         $time, want.data, o_wb.data);
                        end
                end
        end
end

always @(posedge clk) begin
        if (!i_reset) begin
                cycles++;
                if (cycles >= CYCLE_LIMIT) begin
                        other_errors++;
                        $display("Timeout: program did not finish within %0d cycles",
                                 CYCLE_LIMIT);
                        finish_run();
                end
        end
end

endmodule

`default_nettype wire
